/* src/aes_pkg.sv */
package aes_pkg;

  // widths shared by the cipher and the key schedule
  localparam int BLOCK_W = 128;
  localparam int WORD_W = 32;
  localparam int BYTE_W = 8;

  // aes-128 sizes
  localparam int NUM_ROUNDS = 10;
  localparam int NUM_WORDS = 44;

  typedef logic [BLOCK_W-1:0] aes_block_t;
  typedef logic [WORD_W-1:0] aes_word_t;
  typedef logic [BYTE_W-1:0] aes_byte_t;
  typedef logic [3:0] round_idx_t;

  // round constant word for schedule round 1 to 10
  function automatic aes_word_t rcon_for(input round_idx_t rnd);
    aes_byte_t rc;
    case (rnd)
      4'd1: rc = 8'h01;
      4'd2: rc = 8'h02;
      4'd3: rc = 8'h04;
      4'd4: rc = 8'h08;
      4'd5: rc = 8'h10;
      4'd6: rc = 8'h20;
      4'd7: rc = 8'h40;
      4'd8: rc = 8'h80;
      4'd9: rc = 8'h1b;
      4'd10: rc = 8'h36;
      default: rc = 8'h00;
    endcase
    return {rc, 24'h000000};
  endfunction

  // multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t gf_xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // shift and add multiply in gf(2^8)
  function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t acc;
    aes_byte_t p;
    acc = '0;
    p = a;
    for (int k = 0; k < BYTE_W; k++) begin
      if (b[k]) begin
        acc = acc ^ p;
      end
      p = gf_xtime(p);
    end
    return acc;
  endfunction

endpackage

/* src/sbox.sv */
`timescale 1ns/1ps

module sbox
  import aes_pkg::*;
(
  input  aes_byte_t in_byte,
  output aes_byte_t out_byte
);

  //////////////////////////////////////////////////////////////////////
  // multiplicative inverse as in_byte^254
  //////////////////////////////////////////////////////////////////////

  // addition chain over the exponent
  aes_byte_t x2;
  aes_byte_t x3;
  aes_byte_t x6;
  aes_byte_t x12;
  aes_byte_t x15;
  aes_byte_t x30;
  aes_byte_t x60;
  aes_byte_t x120;
  aes_byte_t x240;
  aes_byte_t x252;
  aes_byte_t inv;

  assign x2   = gf_mul(in_byte, in_byte);
  assign x3   = gf_mul(x2, in_byte);
  assign x6   = gf_mul(x3, x3);
  assign x12  = gf_mul(x6, x6);
  assign x15  = gf_mul(x12, x3);
  assign x30  = gf_mul(x15, x15);
  assign x60  = gf_mul(x30, x30);
  assign x120 = gf_mul(x60, x60);
  assign x240 = gf_mul(x120, x120);
  assign x252 = gf_mul(x240, x12);
  // zero input falls out as zero with no special case
  assign inv  = gf_mul(x252, x2);

  //////////////////////////////////////////////////////////////////////
  // affine transform, fips 197 eq. 5.1
  //////////////////////////////////////////////////////////////////////

  // b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
  assign out_byte = inv
                  ^ {inv[6:0], inv[7]}
                  ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]}
                  ^ {inv[3:0], inv[7:4]}
                  ^ 8'h63;

endmodule

/* src/key_expansion.sv */
`timescale 1ns/1ps

module key_expansion
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // pulse that starts a new schedule
  input  logic       start,
  input  aes_block_t init_key,
  input  round_idx_t round_number,
  output aes_block_t round_key,
  // high while the schedule is complete
  output logic       done
);

  typedef enum logic [1:0] {IDLE, LOAD, GEN, DONE} ke_state_t;

  ke_state_t state;
  ke_state_t next_state;

  // full schedule, four words per round key
  aes_word_t w [NUM_WORDS];

  // key captured with start
  aes_block_t key_q;

  // word index, 4 to 44 while generating
  logic [5:0] i;

  aes_word_t w_im1;
  aes_word_t w_im4;
  aes_word_t rot_word;
  aes_word_t sub_word;
  aes_word_t rcon;
  aes_word_t new_word;
  logic accept;
  round_idx_t rk_sel;
  logic [5:0] base;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  // new key only taken when idle or finished
  assign accept = start & ((state == IDLE) | (state == DONE));

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE, DONE: if (start) next_state = LOAD;
      LOAD: next_state = GEN;
      // one extra gen cycle at i == 44 with no write
      GEN: if (i == 6'(NUM_WORDS)) next_state = DONE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      i <= '0;
    end else begin
      case (state)
        LOAD: i <= 6'd4;
        GEN: if (i != 6'(NUM_WORDS)) i <= i + 6'd1;
        default: i <= '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word generation, fips 197 section 5.2
  //////////////////////////////////////////////////////////////////////

  assign w_im1 = w[i - 6'd1];
  assign w_im4 = w[i - 6'd4];

  // rotword moves the top byte to the bottom
  assign rot_word = {w_im1[23:0], w_im1[31:24]};

  // subword, one sbox per byte
  sbox sbox_0 (.in_byte(rot_word[31:24]), .out_byte(sub_word[31:24]));
  sbox sbox_1 (.in_byte(rot_word[23:16]), .out_byte(sub_word[23:16]));
  sbox sbox_2 (.in_byte(rot_word[15:8]),  .out_byte(sub_word[15:8]));
  sbox sbox_3 (.in_byte(rot_word[7:0]),   .out_byte(sub_word[7:0]));

  // i/4 is the schedule round
  assign rcon = rcon_for(i[5:2]);

  assign new_word = w_im4 ^ ((i[1:0] == 2'b00) ? (sub_word ^ rcon) : w_im1);

  always_ff @(posedge clk) begin
    if (accept) begin
      key_q <= init_key;
    end
    if (state == LOAD) begin
      w[0] <= key_q[127:96];
      w[1] <= key_q[95:64];
      w[2] <= key_q[63:32];
      w[3] <= key_q[31:0];
    end else if ((state == GEN) && (i < 6'(NUM_WORDS))) begin
      w[i] <= new_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // round key read
  //////////////////////////////////////////////////////////////////////

  // clamp so the index stays inside the word file
  assign rk_sel = (round_number > round_idx_t'(NUM_ROUNDS)) ?
                  round_idx_t'(NUM_ROUNDS) : round_number;
  assign base = {rk_sel, 2'b00};

  assign round_key = {w[base], w[base + 6'd1], w[base + 6'd2], w[base + 6'd3]};

  assign done = (state == DONE);

endmodule

/* src/aes_round.sv */
`timescale 1ns/1ps

module aes_round
  import aes_pkg::*;
(
  input  aes_block_t state_in,
  input  aes_block_t round_key,
  // skips mixcolumns in the final round
  input  logic       last_round,
  output aes_block_t state_out
);

  // byte n is row n%4, column n/4, taken from the top of the block
  aes_byte_t sub_b [16];
  aes_byte_t shf_b [16];
  aes_byte_t mix_b [16];

  //////////////////////////////////////////////////////////////////////
  // subbytes
  //////////////////////////////////////////////////////////////////////

  genvar g;
  generate
    for (g = 0; g < 16; g++) begin : g_sub
      sbox sbox_i (
        .in_byte (state_in[BLOCK_W-1-8*g -: 8]),
        .out_byte(sub_b[g])
      );
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // shiftrows
  //////////////////////////////////////////////////////////////////////

  // row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shf_b[4*c + r] = sub_b[4*((c + r) % 4) + r];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mixcolumns
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    aes_byte_t a0;
    aes_byte_t a1;
    aes_byte_t a2;
    aes_byte_t a3;
    for (int c = 0; c < 4; c++) begin
      a0 = shf_b[4*c];
      a1 = shf_b[4*c + 1];
      a2 = shf_b[4*c + 2];
      a3 = shf_b[4*c + 3];
      if (last_round) begin
        mix_b[4*c]     = a0;
        mix_b[4*c + 1] = a1;
        mix_b[4*c + 2] = a2;
        mix_b[4*c + 3] = a3;
      end else begin
        // rows of the 02 03 01 01 circulant
        // 03*a is xtime(a) ^ a
        mix_b[4*c]     = gf_xtime(a0) ^ gf_xtime(a1) ^ a1 ^ a2 ^ a3;
        mix_b[4*c + 1] = a0 ^ gf_xtime(a1) ^ gf_xtime(a2) ^ a2 ^ a3;
        mix_b[4*c + 2] = a0 ^ a1 ^ gf_xtime(a2) ^ gf_xtime(a3) ^ a3;
        mix_b[4*c + 3] = gf_xtime(a0) ^ a0 ^ a1 ^ a2 ^ gf_xtime(a3);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // addroundkey
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int n = 0; n < 16; n++) begin
      state_out[BLOCK_W-1-8*n -: 8] = mix_b[n] ^ round_key[BLOCK_W-1-8*n -: 8];
    end
  end

endmodule

/* src/aes_core.sv */
`timescale 1ns/1ps

module aes_core
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // key is sampled with key_load
  input  logic       key_load,
  input  aes_block_t key,
  // plaintext is sampled with start
  input  logic       start,
  input  aes_block_t plaintext,
  output logic       key_ready,
  output logic       busy,
  output logic       done,
  output aes_block_t ciphertext
);

  // working block between rounds
  aes_block_t state_q;

  // 0 before the first round, then 1 to 10
  round_idx_t round_cnt;

  aes_block_t round_key;
  aes_block_t round_out;
  logic key_start;
  logic start_ok;
  logic last_round;

  //////////////////////////////////////////////////////////////////////
  // command gating
  //////////////////////////////////////////////////////////////////////

  // no schedule reload while a block is in flight
  assign key_start = key_load & ~busy;

  // start needs a finished schedule and an idle datapath
  assign start_ok = start & key_ready & ~busy;

  assign last_round = (round_cnt == round_idx_t'(NUM_ROUNDS));

  //////////////////////////////////////////////////////////////////////
  // key schedule and round datapath
  //////////////////////////////////////////////////////////////////////

  // round key follows the round counter
  key_expansion key_expansion_i (
    .clk         (clk),
    .reset       (reset),
    .start       (key_start),
    .init_key    (key),
    .round_number(round_cnt),
    .round_key   (round_key),
    .done        (key_ready)
  );

  aes_round aes_round_i (
    .state_in  (state_q),
    .round_key (round_key),
    .last_round(last_round),
    .state_out (round_out)
  );

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  // counter sits at 0 when idle, so round_key is key 0 here
  always_ff @(posedge clk) begin
    if (start_ok) begin
      state_q <= plaintext ^ round_key;
    end else if (busy) begin
      state_q <= round_out;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // round sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      busy       <= 1'b0;
      done       <= 1'b0;
      round_cnt  <= '0;
      ciphertext <= '0;
    end else begin
      // single cycle pulse
      done <= 1'b0;
      if (start_ok) begin
        busy      <= 1'b1;
        round_cnt <= round_idx_t'(1);
      end else if (busy) begin
        if (last_round) begin
          // result held until the next block finishes
          busy       <= 1'b0;
          done       <= 1'b1;
          round_cnt  <= '0;
          ciphertext <= round_out;
        end else begin
          round_cnt <= round_cnt + round_idx_t'(1);
        end
      end
    end
  end

endmodule

/* testbench/aes_core_sva.sv */
`timescale 1ns/1ps

module aes_core_sva (
  input logic clk,
  input logic reset,
  input logic key_ready,
  input logic busy,
  input logic done
);

  //////////////////////////////////////////////////////////////////////
  // output pulse shape
  //////////////////////////////////////////////////////////////////////

  // done never stretches past one cycle
  done_single_cycle: assert property (
    @(posedge clk) disable iff (!reset) done |=> !done
  ) else $error("done stayed high for more than one cycle");

  // the last round runs with busy high, so done always follows busy
  done_after_busy: assert property (
    @(posedge clk) disable iff (!reset) done |-> $past(busy)
  ) else $error("done rose without busy in the previous cycle");

  //////////////////////////////////////////////////////////////////////
  // reset and control ordering
  //////////////////////////////////////////////////////////////////////

  // synchronous reset clears both levels by the next edge
  idle_after_reset: assert property (
    @(posedge clk) !reset |=> (!busy && !key_ready)
  ) else $error("busy or key_ready high in the cycle after reset");

  // a block only starts on a finished key schedule
  busy_needs_key: assert property (
    @(posedge clk) disable iff (!reset) $rose(busy) |-> $past(key_ready)
  ) else $error("busy rose while key_ready was low");

endmodule

/* testbench/aes_core_tb.sv */
`timescale 1ns/1ps

module aes_core_tb
  import aes_pkg::*;
();

  // edge counts from the core timing rules
  localparam int KEY_READY_EDGES = 42;
  localparam int ROUND_EDGES = 10;
  localparam int BLOCK_GAP = 11;
  localparam int WAIT_LIMIT = 200;

  logic clk;
  logic reset;
  logic key_load;
  aes_block_t key;
  logic start;
  aes_block_t plaintext;
  logic key_ready;
  logic busy;
  logic done;
  aes_block_t ciphertext;

  int errors;
  int timeouts;
  bit summary_done;

  // vector table
  // 0 fips 197 appendix b, 1 appendix c.1, 2 to 4 sp 800-38a ecb blocks
  aes_block_t vec_key [2];
  aes_block_t vec_pt [5];
  aes_block_t vec_ct [5];

  aes_core aes_core_i (
    .clk       (clk),
    .reset     (reset),
    .key_load  (key_load),
    .key       (key),
    .start     (start),
    .plaintext (plaintext),
    .key_ready (key_ready),
    .busy      (busy),
    .done      (done),
    .ciphertext(ciphertext)
  );

  bind aes_core aes_core_sva aes_core_sva_i (
    .clk      (clk),
    .reset    (reset),
    .key_ready(key_ready),
    .busy     (busy),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fill_vectors();
    vec_key[0] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    vec_pt[0]  = 128'h3243f6a8885a308d313198a2e0370734;
    vec_ct[0]  = 128'h3925841d02dc09fbdc118597196a0b32;
    vec_key[1] = 128'h000102030405060708090a0b0c0d0e0f;
    vec_pt[1]  = 128'h00112233445566778899aabbccddeeff;
    vec_ct[1]  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    // ecb blocks share the appendix b key
    vec_pt[2]  = 128'h6bc1bee22e409f96e93d7e117393172a;
    vec_ct[2]  = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
    vec_pt[3]  = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
    vec_ct[3]  = 128'hf5d3d58503b9699de785895a96fdbaaf;
    vec_pt[4]  = 128'h30c81c46a35ce411e5fbc1191a0a52ef;
    vec_ct[4]  = 128'h43b1cd7f598ece23881b00e3ed030688;
  endtask

  // inputs change 1 ns after the rising edge, outputs are settled by then
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("[ERROR] t=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    assert (act == exp) else begin
      $display("[ERROR] t=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_block(input string name, input aes_block_t exp, input aes_block_t act);
    assert (act === exp) else begin
      $display("[ERROR] t=%0t %s expected=%032h actual=%032h", $time, name, exp, act);
      errors++;
    end
  endtask

  // edges counts clock edges until key_ready is seen high
  task automatic wait_key_ready(output int edges);
    edges = 0;
    while (key_ready !== 1'b1 && edges < WAIT_LIMIT) begin
      step();
      edges++;
    end
    if (key_ready !== 1'b1) begin
      $display("timeout: key_ready did not rise within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic wait_done(output int edges);
    edges = 0;
    while (done !== 1'b1 && edges < WAIT_LIMIT) begin
      step();
      edges++;
    end
    if (done !== 1'b1) begin
      $display("timeout: done did not pulse within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
  endtask

  // one cycle start with its plaintext
  task automatic pulse_start(input aes_block_t pt);
    plaintext = pt;
    start = 1'b1;
    step();
    start = 1'b0;
  endtask

  task automatic load_key(input aes_block_t k, input bit check_timing);
    int edges;
    key = k;
    key_load = 1'b1;
    step();
    key_load = 1'b0;
    // schedule restarts on the sampling edge
    check_bit("key_ready", 1'b0, key_ready);
    wait_key_ready(edges);
    if (check_timing) begin
      check_count("key_ready edges", KEY_READY_EDGES, edges);
    end
  endtask

  task automatic encrypt_block(input aes_block_t pt, input aes_block_t exp_ct);
    int edges;
    pulse_start(pt);
    check_bit("busy", 1'b1, busy);
    wait_done(edges);
    check_count("done edges", ROUND_EDGES, edges);
    check_block("ciphertext", exp_ct, ciphertext);
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      check_bit("busy", 1'b0, busy);
      check_bit("done", 1'b0, done);
      step();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_schedule();
    check_bit("key_ready", 1'b0, key_ready);
    check_block("ciphertext", 128'h0, ciphertext);
    expect_idle(2);
    load_key(vec_key[0], 1'b1);
  endtask

  task automatic test_appendix_b();
    encrypt_block(vec_pt[0], vec_ct[0]);
    step();
    expect_idle(3);
    // result is held after the pulse
    check_block("ciphertext", vec_ct[0], ciphertext);
  endtask

  // new key over a finished schedule
  task automatic test_appendix_c();
    load_key(vec_key[1], 1'b1);
    encrypt_block(vec_pt[1], vec_ct[1]);
    step();
    expect_idle(2);
  endtask

  task automatic test_back_to_back();
    int edges;
    load_key(vec_key[0], 1'b0);
    pulse_start(vec_pt[2]);
    wait_done(edges);
    check_block("ciphertext", vec_ct[2], ciphertext);
    for (int b = 3; b < 5; b++) begin
      // next block goes in while done is high
      pulse_start(vec_pt[b]);
      check_bit("busy", 1'b1, busy);
      wait_done(edges);
      // the start edge plus the round edges
      check_count("done spacing", BLOCK_GAP, edges + 1);
      check_block("ciphertext", vec_ct[b], ciphertext);
    end
    step();
  endtask

  task automatic test_ignored_commands();
    int edges;
    key = vec_key[1];
    key_load = 1'b1;
    step();
    key_load = 1'b0;
    // schedule still running
    pulse_start(vec_pt[0]);
    expect_idle(2);
    check_bit("key_ready", 1'b0, key_ready);
    wait_key_ready(edges);
    pulse_start(vec_pt[1]);
    check_bit("busy", 1'b1, busy);
    // second start and a new key while the block is in flight
    key = vec_key[0];
    key_load = 1'b1;
    plaintext = vec_pt[0];
    start = 1'b1;
    step();
    key_load = 1'b0;
    start = 1'b0;
    check_bit("busy", 1'b1, busy);
    check_bit("key_ready", 1'b1, key_ready);
    wait_done(edges);
    // one round edge already spent on the ignored commands
    check_count("done edges", ROUND_EDGES - 1, edges);
    check_block("ciphertext", vec_ct[1], ciphertext);
    step();
    check_bit("busy", 1'b0, busy);
    check_bit("key_ready", 1'b1, key_ready);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    errors = 0;
    timeouts = 0;
    summary_done = 1'b0;
    reset = 1'b0;
    key_load = 1'b0;
    key = '0;
    start = 1'b0;
    plaintext = '0;
    fill_vectors();
    repeat (3) step();
    reset = 1'b1;

    test_reset_schedule();
    test_appendix_b();
    test_appendix_c();
    test_back_to_back();
    test_ignored_commands();

    $display("summary: %0d failed checks, %0d timeouts", errors, timeouts);
    summary_done = 1'b1;
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // run stopped early, e.g. by a failing bound assertion
  final begin
    if (!summary_done) begin
      $display("SIMULATION FAILED");
    end
  end

endmodule

/* tb.f */
src/aes_pkg.sv
src/sbox.sv
src/key_expansion.sv
src/aes_round.sv
src/aes_core.sv
testbench/aes_core_sva.sv
testbench/aes_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the aes_core testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal -j 0 \
  --top-module aes_core_tb \
  -f tb.f \
  -o aes_core_sim

./obj_dir/aes_core_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
echo "run.sh: testbench reported failure, see sim.log"
exit 1
